//--- Bender.yml
package:
  name: flit_buffer

sources:
  - logic/flit_buffer_pkg.sv
  - logic/vc_ptr_ctrl.sv
  - logic/flit_ram.sv
  - logic/flit_buffer.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/flit_buffer_tb.sv

//--- logic/flit_buffer.sv
module flit_buffer (
    input  logic                      clk,
    input  logic                      reset,
    // write side
    input  logic                      wr_en,
    input  flit_buffer_pkg::vc_mask_t wr_vc,
    input  flit_buffer_pkg::flit_t    wr_flit,
    // read side
    input  logic                      rd_en,
    input  flit_buffer_pkg::vc_mask_t rd_vc,
    output flit_buffer_pkg::flit_t    rd_flit,
    // per-channel occupancy for the switch allocator
    output flit_buffer_pkg::vc_mask_t vc_not_empty
);

    import flit_buffer_pkg::*;

    // addresses into the shared memory
    ram_addr_t ram_wr_addr;
    ram_addr_t ram_rd_addr;

    // pointers, depths and address generation
    vc_ptr_ctrl ptr_ctrl_i (
        .clk          (clk),
        .reset        (reset),
        .wr_en        (wr_en),
        .rd_en        (rd_en),
        .wr_vc        (wr_vc),
        .rd_vc        (rd_vc),
        .ram_wr_addr  (ram_wr_addr),
        .ram_rd_addr  (ram_rd_addr),
        .vc_not_empty (vc_not_empty)
    );

    // shared flit storage
    // write lands at the edge, read data follows one cycle later
    flit_ram ram_i (
        .clk     (clk),
        .wr_en   (wr_en),
        .rd_en   (rd_en),
        .wr_addr (ram_wr_addr),
        .rd_addr (ram_rd_addr),
        .wr_data (wr_flit),
        .rd_data (rd_flit)
    );

endmodule

//--- logic/flit_buffer_pkg.sv
package flit_buffer_pkg;

    // buffer geometry

    // virtual channels sharing one router input port
    localparam int NUM_VC = 2;

    // flits per channel, power of two so the pointers wrap on their own
    localparam int VC_DEPTH = 4;

    // flit payload bits, without the hdr/tail marks
    localparam int PAYLOAD_W = 32;

    // derived widths

    // per-channel slot index
    localparam int PTR_W = $clog2(VC_DEPTH);

    // one extra bit so a full channel is distinct from an empty one
    localparam int DEPTH_W = PTR_W + 1;

    // binary channel index, kept at least one bit wide
    localparam int VC_SEL_W = (NUM_VC > 1) ? $clog2(NUM_VC) : 1;

    // shared memory address, channel region on top, slot below
    localparam int RAM_ADDR_W = VC_SEL_W + PTR_W;

    // total flit slots in the shared memory
    localparam int RAM_WORDS = NUM_VC * VC_DEPTH;

    // one bit per channel
    // used for write/read selects and the not-empty flags
    typedef logic [NUM_VC-1:0] vc_mask_t;

    // binary channel number
    typedef logic [VC_SEL_W-1:0] vc_sel_t;

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [DEPTH_W-1:0] depth_t;

    // memory address, {channel, slot}
    typedef logic [RAM_ADDR_W-1:0] ram_addr_t;

    // flit as stored in the buffer
    // hdr opens a packet, tail closes it
    // a single-flit packet has both set
    typedef struct packed {
        logic                 hdr;
        logic                 tail;
        logic [PAYLOAD_W-1:0] payload;
    } flit_t;

endpackage

//--- logic/flit_ram.sv
module flit_ram (
    input  logic                       clk,
    input  logic                       wr_en,
    input  logic                       rd_en,
    input  flit_buffer_pkg::ram_addr_t wr_addr,
    input  flit_buffer_pkg::ram_addr_t rd_addr,
    input  flit_buffer_pkg::flit_t     wr_data,
    output flit_buffer_pkg::flit_t     rd_data
);

    import flit_buffer_pkg::*;

    // all channel regions back to back
    // channel v owns words v*VC_DEPTH .. v*VC_DEPTH+VC_DEPTH-1
    flit_t mem [RAM_WORDS];

    // read register, holds between reads
    flit_t rd_q;

    // simple dual port
    // same-address write and read returns the old word
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        if (rd_en) begin
            rd_q <= mem[rd_addr];
        end
    end

    // data out one cycle after the read address
    assign rd_data = rd_q;

    // an unknown address would corrupt or read an arbitrary slot
    // addresses come from the pointer controller, so this also
    // catches unknown selects upstream
    a_wr_addr_known: assert property (
        @(posedge clk)
        wr_en |-> !$isunknown(wr_addr)
    ) else $error("unknown write address");

    a_rd_addr_known: assert property (
        @(posedge clk)
        rd_en |-> !$isunknown(rd_addr)
    ) else $error("unknown read address");

endmodule

//--- logic/vc_ptr_ctrl.sv
module vc_ptr_ctrl (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      wr_en,
    input  logic                      rd_en,
    input  flit_buffer_pkg::vc_mask_t wr_vc,
    input  flit_buffer_pkg::vc_mask_t rd_vc,
    output flit_buffer_pkg::ram_addr_t ram_wr_addr,
    output flit_buffer_pkg::ram_addr_t ram_rd_addr,
    output flit_buffer_pkg::vc_mask_t vc_not_empty
);

    import flit_buffer_pkg::*;

    // per-channel state
    ptr_t   wr_ptr [NUM_VC];
    ptr_t   rd_ptr [NUM_VC];
    depth_t depth  [NUM_VC];

    // selects qualified by their enables
    vc_mask_t wr_mask;
    vc_mask_t rd_mask;

    // binary channel numbers from the one-hot selects
    vc_sel_t wr_idx;
    vc_sel_t rd_idx;

    // pointer of the selected channel
    ptr_t wr_ptr_sel;
    ptr_t rd_ptr_sel;

    // a channel only moves when its enable is high
    assign wr_mask = wr_en ? wr_vc : '0;
    assign rd_mask = rd_en ? rd_vc : '0;

    // one-hot to binary plus pointer mux
    // and-or form, each select bit gates its own channel
    // relies on one-hot selects, see the assertions below
    always_comb begin
        wr_idx     = '0;
        rd_idx     = '0;
        wr_ptr_sel = '0;
        rd_ptr_sel = '0;
        for (int v = 0; v < NUM_VC; v++) begin
            if (wr_vc[v]) begin
                wr_idx     = wr_idx | vc_sel_t'(v);
                wr_ptr_sel = wr_ptr_sel | wr_ptr[v];
            end
            if (rd_vc[v]) begin
                rd_idx     = rd_idx | vc_sel_t'(v);
                rd_ptr_sel = rd_ptr_sel | rd_ptr[v];
            end
        end
    end

    // channel picks the region, pointer picks the slot in it
    assign ram_wr_addr = {wr_idx, wr_ptr_sel};
    assign ram_rd_addr = {rd_idx, rd_ptr_sel};

    for (genvar v = 0; v < NUM_VC; v++) begin : g_vc

        always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
                wr_ptr[v] <= '0;
                rd_ptr[v] <= '0;
                depth[v]  <= '0;
            end else begin
                // pointers wrap modulo VC_DEPTH by width
                if (wr_mask[v]) begin
                    wr_ptr[v] <= wr_ptr[v] + 1'b1;
                end
                if (rd_mask[v]) begin
                    rd_ptr[v] <= rd_ptr[v] + 1'b1;
                end
                // write and read together leave the depth alone
                if (wr_mask[v] && !rd_mask[v]) begin
                    depth[v] <= depth[v] + 1'b1;
                end else if (!wr_mask[v] && rd_mask[v]) begin
                    depth[v] <= depth[v] - 1'b1;
                end
            end
        end

        // flag straight from the registered depth
        assign vc_not_empty[v] = (depth[v] != '0);

        // overflow, no back-pressure so the sender must count credits
        a_no_wr_full: assert property (
            @(posedge clk) disable iff (reset)
            wr_mask[v] |-> (depth[v] < depth_t'(VC_DEPTH))
        ) else $error("write into full channel %0d", v);

        // underflow, also covers a same-cycle pair on an empty channel
        a_no_rd_empty: assert property (
            @(posedge clk) disable iff (reset)
            rd_mask[v] |-> (depth[v] != '0)
        ) else $error("read from empty channel %0d", v);

        // each write steps the write pointer by exactly one slot
        a_wr_ptr_step: assert property (
            @(posedge clk) disable iff (reset)
            wr_mask[v] |=> (wr_ptr[v] == ptr_t'($past(wr_ptr[v]) + 1'b1))
        ) else $error("write pointer of channel %0d did not advance", v);

        // same for reads
        a_rd_ptr_step: assert property (
            @(posedge clk) disable iff (reset)
            rd_mask[v] |=> (rd_ptr[v] == ptr_t'($past(rd_ptr[v]) + 1'b1))
        ) else $error("read pointer of channel %0d did not advance", v);

        // depth bounded by the region size
        a_depth_max: assert property (
            @(posedge clk) disable iff (reset)
            depth[v] <= depth_t'(VC_DEPTH)
        ) else $error("depth of channel %0d above VC_DEPTH", v);

    end

    // the and-or mux above breaks on zero or multiple select bits
    a_wr_onehot: assert property (
        @(posedge clk) disable iff (reset)
        wr_en |-> $onehot(wr_vc)
    ) else $error("wr_vc not one-hot while wr_en high");

    a_rd_onehot: assert property (
        @(posedge clk) disable iff (reset)
        rd_en |-> $onehot(rd_vc)
    ) else $error("rd_vc not one-hot while rd_en high");

endmodule

//--- tb/flit_buffer_checks.svh
`ifndef FLIT_BUFFER_CHECKS_SVH
`define FLIT_BUFFER_CHECKS_SVH

// all flags clear right after reset release
a_reset_clear: assert property (
    @(posedge clk)
    $fell(reset) |-> (vc_not_empty == '0)
) else value_error($sformatf("vc_not_empty %b after reset, expected 0",
                             $sampled(vc_not_empty)));

// read data one cycle after the read edge
// expected flit comes from the model queue
a_rd_known: assert property (
    @(posedge clk) disable iff (reset)
    rd_due |-> !$isunknown(rd_flit)
) else value_error("rd_flit has unknown bits after a read");

a_rd_hdr: assert property (
    @(posedge clk) disable iff (reset)
    rd_due |-> (rd_flit.hdr == exp_flit.hdr)
) else value_error($sformatf("rd_flit.hdr %b, expected %b",
                             $sampled(rd_flit.hdr), $sampled(exp_flit.hdr)));

a_rd_tail: assert property (
    @(posedge clk) disable iff (reset)
    rd_due |-> (rd_flit.tail == exp_flit.tail)
) else value_error($sformatf("rd_flit.tail %b, expected %b",
                             $sampled(rd_flit.tail), $sampled(exp_flit.tail)));

// payload mismatch also exposes a flit from the wrong channel
a_rd_payload: assert property (
    @(posedge clk) disable iff (reset)
    rd_due |-> (rd_flit.payload == exp_flit.payload)
) else value_error($sformatf("rd_flit.payload %h, expected %h",
                             $sampled(rd_flit.payload), $sampled(exp_flit.payload)));

// flags track model occupancy one cycle after each edge
a_flags: assert property (
    @(posedge clk) disable iff (reset)
    flags_valid |-> (vc_not_empty == model_mask)
) else value_error($sformatf("vc_not_empty %b, expected %b",
                             $sampled(vc_not_empty), $sampled(model_mask)));

// write plus read on one channel, depth and flag unchanged
a_same_pair_flag: assert property (
    @(posedge clk) disable iff (reset)
    same_pair |-> $stable(vc_not_empty)
) else value_error($sformatf("vc_not_empty moved to %b on a same-channel pair",
                             $sampled(vc_not_empty)));

// stimulus must never read an empty channel
a_model_no_underflow: assert property (
    @(posedge clk)
    !model_underflow
) else report_failure("stimulus read from a channel the model holds as empty");

`endif

//--- tb/flit_buffer_tb.sv
module flit_buffer_tb;

    import flit_buffer_pkg::*;

    localparam int CLK_PERIOD    = 100;
    // inputs change this long after the rising edge
    localparam int DRIVE_DELAY   = 10;
    localparam int SEED          = 81765;
    // enough full rounds for every pointer to wrap more than once
    localparam int WRAP_ROUNDS   = 3;
    localparam int RANDOM_CYCLES = 400;
    localparam int FLAG_TIMEOUT  = 8;
    localparam int DRAIN_TIMEOUT = 4 * VC_DEPTH;
    localparam int MAX_CYCLES    = 5000;

    // DUT ports
    logic     clk;
    logic     reset;
    logic     wr_en;
    vc_mask_t wr_vc;
    flit_t    wr_flit;
    logic     rd_en;
    vc_mask_t rd_vc;
    flit_t    rd_flit;
    vc_mask_t vc_not_empty;

    // reference model, one queue per channel
    flit_t    model_q [NUM_VC][$];
    // flit popped at the last read edge
    flit_t    exp_flit;
    vc_mask_t model_mask      = '0;
    bit       rd_due          = 1'b0;
    bit       same_pair       = 1'b0;
    bit       flags_valid     = 1'b0;
    bit       model_underflow = 1'b0;

    // xorshift state
    logic [31:0] rng_state = SEED;

    task automatic stop_failed();
        $display("Simulation failed");
        $fatal(1);
    endtask

    // wrong value seen by a check
    task automatic value_error(input string msg);
        $display("ERROR at time %0t: %s", $time, msg);
        stop_failed();
    endtask

    // timeouts and model trouble
    task automatic report_failure(input string msg);
        $display("%s (time %0t)", msg, $time);
        stop_failed();
    endtask

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    flit_buffer dut_i (
        .clk          (clk),
        .reset        (reset),
        .wr_en        (wr_en),
        .wr_vc        (wr_vc),
        .wr_flit      (wr_flit),
        .rd_en        (rd_en),
        .rd_vc        (rd_vc),
        .rd_flit      (rd_flit),
        .vc_not_empty (vc_not_empty)
    );

    // model follows the DUT edge by edge
    // pop before push, so a same-cycle pair returns the older flit
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int v = 0; v < NUM_VC; v++) begin
                model_q[v].delete();
            end
            model_mask  = '0;
            rd_due      = 1'b0;
            same_pair   = 1'b0;
            flags_valid = 1'b0;
        end else begin
            rd_due = 1'b0;
            for (int v = 0; v < NUM_VC; v++) begin
                if (rd_en && rd_vc[v]) begin
                    if (model_q[v].size() == 0) begin
                        model_underflow = 1'b1;
                    end else begin
                        exp_flit = model_q[v].pop_front();
                        rd_due   = 1'b1;
                    end
                end
            end
            for (int v = 0; v < NUM_VC; v++) begin
                if (wr_en && wr_vc[v]) begin
                    model_q[v].push_back(wr_flit);
                end
            end
            same_pair = wr_en && rd_en && (wr_vc == rd_vc);
            for (int v = 0; v < NUM_VC; v++) begin
                model_mask[v] = (model_q[v].size() > 0);
            end
            flags_valid = 1'b1;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    // one cycle of traffic, random flit contents
    task automatic present(input logic do_wr, input int wv, input logic do_rd, input int rv);
        logic [31:0] r;
        r = next_random();
        wr_en           = do_wr;
        wr_vc           = do_wr ? (vc_mask_t'(1) << wv) : '0;
        wr_flit.hdr     = r[0];
        wr_flit.tail    = r[1];
        wr_flit.payload = next_random();
        rd_en           = do_rd;
        rd_vc           = do_rd ? (vc_mask_t'(1) << rv) : '0;
        next_cycle();
    endtask

    task automatic wait_flag(input int v, input logic value);
        int n;
        n = 0;
        while (vc_not_empty[v] !== value && n < FLAG_TIMEOUT) begin
            present(1'b0, 0, 1'b0, 0);
            n++;
        end
        if (vc_not_empty[v] !== value) begin
            report_failure($sformatf("timeout: not-empty flag of channel %0d never became %0b",
                                     v, value));
        end
    endtask

    // fill each channel to the brim, then empty it
    task automatic fill_and_wrap();
        for (int round = 0; round < WRAP_ROUNDS; round++) begin
            for (int v = 0; v < NUM_VC; v++) begin
                for (int i = 0; i < VC_DEPTH; i++) begin
                    present(1'b1, v, 1'b0, 0);
                end
                wait_flag(v, 1'b1);
                for (int i = 0; i < VC_DEPTH; i++) begin
                    present(1'b0, 0, 1'b1, v);
                end
                wait_flag(v, 1'b0);
            end
        end
    endtask

    task automatic same_cycle_pairs();
        // one flit in channel 0 so the pairs are legal
        present(1'b1, 0, 1'b0, 0);
        repeat (6) present(1'b1, 0, 1'b1, 0);
        present(1'b1, 1, 1'b0, 0);
        // cross pairs, counts stay between zero and two
        repeat (4) begin
            present(1'b1, 0, 1'b1, 1);
            present(1'b1, 1, 1'b1, 0);
        end
        repeat (3) present(1'b1, 1, 1'b1, 1);
    endtask

    task automatic random_traffic();
        logic [31:0] r;
        int          wv;
        int          rv;
        logic        do_wr;
        logic        do_rd;
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            r     = next_random();
            wv    = int'(r[7:0]) % NUM_VC;
            rv    = int'(r[15:8]) % NUM_VC;
            // never overflow, never underflow
            do_wr = r[16] && (model_q[wv].size() < VC_DEPTH);
            do_rd = r[17] && (model_q[rv].size() > 0);
            present(do_wr, wv, do_rd, rv);
        end
    endtask

    task automatic drain_all();
        int n;
        for (int v = 0; v < NUM_VC; v++) begin
            n = 0;
            while (model_q[v].size() > 0 && n < DRAIN_TIMEOUT) begin
                present(1'b0, 0, 1'b1, v);
                n++;
            end
            wait_flag(v, 1'b0);
        end
    endtask

    initial begin
        reset   = 1'b1;
        wr_en   = 1'b0;
        wr_vc   = '0;
        wr_flit = '0;
        rd_en   = 1'b0;
        rd_vc   = '0;
        repeat (2) @(posedge clk);
        #(DRIVE_DELAY);
        reset = 1'b0;
        // idle edge so the reset check sees the release
        present(1'b0, 0, 1'b0, 0);
        fill_and_wrap();
        same_cycle_pairs();
        random_traffic();
        drain_all();
        repeat (2) present(1'b0, 0, 1'b0, 0);
        $display("Simulation passed");
        $finish;
    end

    // hard limit on the whole run
    initial begin : watchdog
        repeat (MAX_CYCLES) @(posedge clk);
        report_failure($sformatf("timeout: run did not finish within %0d clock cycles",
                                 MAX_CYCLES));
    end

    `include "flit_buffer_checks.svh"

endmodule

//--- verilog.f
+incdir+tb
logic/flit_buffer_pkg.sv
logic/vc_ptr_ctrl.sv
logic/flit_ram.sv
logic/flit_buffer.sv
tb/flit_buffer_tb.sv
